// File: all.f
+incdir+include
verilog/mbxWordPkg.sv
verilog/mbxCyclePkg.sv
verilog/wordRequestMask.sv
verilog/mbBufferTracker.sv
verilog/memCycleControl.sv
verilog/mbxControl.sv
bench/mbxChecker.sv
bench/mbxBench.sv

// File: run.sh
#!/bin/sh
# Build the bench with Verilator, run it, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ns --top-module mbxBench -f all.f \
  -o mbxSim > sim.log 2>&1 \
  && ./obj_dir/mbxSim >> sim.log 2>&1 \
  || echo "ERRORS FOUND" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && echo "Simulation failed" && exit 1
echo "Simulation passed"
exit 0

// File: include/mbxBenchTable.svh
////////////////////////////////////////
// Bench table with one memory cycle per row
////////////////////////////////////////

// Columns of one row
typedef struct packed {
  // Buffer words loaded before the start
  mbxWordPkg::wordMask   wordLoad;
  mbxCyclePkg::cycleKind kind;
  mbxWordPkg::wordIndex  wordAdr;
  mbxWordPkg::wordMask   cacheValid;
  // Second start while the cycle runs
  logic                  retrigger;
  // Cycles from one acknowledge to the next
  logic [3:0]            ackGap;
  mbxWordPkg::wordMask   expRqIn;
  // Served words in order with the first in the low bits
  logic [3:0][1:0]       expAdrSeq;
  mbxWordPkg::wordMask   expPending;
} benchRow;

localparam int rowCount = 7;

localparam benchRow rows [rowCount] = '{
  '{4'b0000, mbxCyclePkg::oneWordRead, 2'd2, 4'b0000, 1'b0, 4'd2,
    4'b0100, {2'd0, 2'd0, 2'd0, 2'd2}, 4'b0000},
  '{4'b0000, mbxCyclePkg::coreRead, 2'd0, 4'b1001, 1'b0, 4'd3,
    4'b0110, {2'd0, 2'd0, 2'd2, 2'd1}, 4'b0000},
  '{4'b1010, mbxCyclePkg::writeback, 2'd0, 4'b0000, 1'b0, 4'd2,
    4'b1010, {2'd0, 2'd0, 2'd3, 2'd1}, 4'b0000},
  '{4'b0000, mbxCyclePkg::pageRefill, 2'd0, 4'b0001, 1'b1, 4'd2,
    4'b1110, {2'd0, 2'd3, 2'd2, 2'd1}, 4'b0000},
  '{4'b0000, mbxCyclePkg::coreRead, 2'd1, 4'b1111, 1'b0, 4'd2,
    4'b0000, {2'd0, 2'd0, 2'd0, 2'd0}, 4'b0000},
  '{4'b0100, mbxCyclePkg::oneWordWrite, 2'd2, 4'b0000, 1'b0, 4'd2,
    4'b0100, {2'd0, 2'd0, 2'd0, 2'd2}, 4'b0000},
  // Read cycle leaves the loaded word waiting in the buffer
  '{4'b0001, mbxCyclePkg::coreRead, 2'd0, 4'b1110, 1'b0, 4'd3,
    4'b0001, {2'd0, 2'd0, 2'd0, 2'd0}, 4'b0001}
};

function automatic string rowName(int r);
  case (r)
    0: return "oneWordRead";
    1: return "coreReadMiss";
    2: return "writeback";
    3: return "startWhileBusy";
    4: return "allValid";
    5: return "oneWordWrite";
    6: return "readKeepsPending";
    default: return "unknown";
  endcase
endfunction

// File: bench/mbxBench.sv
module mbxBench;
  timeunit 1ns;
  timeprecision 1ns;

  `include "mbxBenchTable.svh"

  localparam int clkPeriod = 100;
  localparam int rowCycles = 40;

  logic                  clk;
  logic                  reset;
  logic                  cycleStart;
  mbxCyclePkg::cycleKind cycleKind;
  mbxWordPkg::wordIndex  wordAdr;
  mbxWordPkg::wordMask   cacheValid;
  mbxWordPkg::wordMask   wordLoad;
  logic                  memAckn;
  mbxWordPkg::wordMask   rqIn;
  logic                  memRdRq;
  logic                  memWrRq;
  mbxWordPkg::wordIndex  memWordAdr;
  logic                  busy;
  mbxWordPkg::wordIndex  mbSel;
  logic                  mbReqHold;
  int                    rowIdx;
  logic                  rowEnd;
  logic                  runDone;
  int                    errorCount;
  int                    checkCount;

  mbxControl mbxControl_i (
    .clk        (clk),
    .reset      (reset),
    .cycleStart (cycleStart),
    .cycleKind  (cycleKind),
    .wordAdr    (wordAdr),
    .cacheValid (cacheValid),
    .wordLoad   (wordLoad),
    .memAckn    (memAckn),
    .rqIn       (rqIn),
    .memRdRq    (memRdRq),
    .memWrRq    (memWrRq),
    .memWordAdr (memWordAdr),
    .busy       (busy),
    .mbSel      (mbSel),
    .mbReqHold  (mbReqHold)
  );

  mbxChecker mbxChecker_i (
    .clk        (clk),
    .reset      (reset),
    .rowIdx     (rowIdx),
    .rowEnd     (rowEnd),
    .runDone    (runDone),
    .cycleStart (cycleStart),
    .wordLoad   (wordLoad),
    .memAckn    (memAckn),
    .rqIn       (rqIn),
    .memRdRq    (memRdRq),
    .memWrRq    (memWrRq),
    .memWordAdr (memWordAdr),
    .busy       (busy),
    .mbSel      (mbSel),
    .mbReqHold  (mbReqHold),
    .errorCount (errorCount),
    .checkCount (checkCount)
  );

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////
  // Stimulus driven on the falling edge
  ////////////////////////////////////////

  task automatic pulseLoad(mbxWordPkg::wordMask mask);
    wordLoad = mask;
    @(negedge clk);
    wordLoad = '0;
    // Select and hold register one cycle after the flags
    @(negedge clk);
  endtask

  task automatic pulseStart(mbxCyclePkg::cycleKind kind, mbxWordPkg::wordIndex adr,
                            mbxWordPkg::wordMask valid);
    cycleKind  = kind;
    wordAdr    = adr;
    cacheValid = valid;
    cycleStart = 1'b1;
    @(negedge clk);
    cycleStart = 1'b0;
  endtask

  // Memory answers one acknowledge per word until busy drops
  task automatic answerWords(int gap);
    int served;
    served = 0;
    while (busy && served < mbxWordPkg::wordCount) begin
      repeat (gap - 1) @(negedge clk);
      memAckn = 1'b1;
      @(negedge clk);
      memAckn = 1'b0;
      served++;
    end
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    cycleStart = 1'b0;
    cycleKind  = mbxCyclePkg::coreRead;
    wordAdr    = '0;
    cacheValid = '0;
    wordLoad   = '0;
    memAckn    = 1'b0;
    rowIdx     = 0;
    rowEnd     = 1'b0;
    runDone    = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    for (int r = 0; r < rowCount; r++) begin
      rowIdx = r;
      if (rows[r].wordLoad != '0) begin
        pulseLoad(rows[r].wordLoad);
      end
      pulseStart(rows[r].kind, rows[r].wordAdr, rows[r].cacheValid);
      if (rows[r].retrigger) begin
        @(negedge clk);
        // Would be accepted if the first cycle were not running
        pulseStart(mbxCyclePkg::oneWordRead, '0, rows[r].cacheValid);
      end
      answerWords(int'(rows[r].ackGap));
      @(negedge clk);
      rowEnd = 1'b1;
      @(negedge clk);
      rowEnd = 1'b0;
    end
    runDone = 1'b1;
    @(negedge clk);
    runDone = 1'b0;
    @(posedge clk);
    if (errorCount == 0 && checkCount > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(rowCount * rowCycles * clkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", rowCount * rowCycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: bench/mbxChecker.sv
module mbxChecker (
  input  logic                 clk,
  input  logic                 reset,
  input  int                   rowIdx,
  input  logic                 rowEnd,
  input  logic                 runDone,
  input  logic                 cycleStart,
  input  mbxWordPkg::wordMask  wordLoad,
  input  logic                 memAckn,
  input  mbxWordPkg::wordMask  rqIn,
  input  logic                 memRdRq,
  input  logic                 memWrRq,
  input  mbxWordPkg::wordIndex memWordAdr,
  input  logic                 busy,
  input  mbxWordPkg::wordIndex mbSel,
  input  logic                 mbReqHold,
  output int                   errorCount,
  output int                   checkCount
);
  timeunit 1ns;
  timeprecision 1ns;

  `include "mbxBenchTable.svh"

  logic                 cReset;
  logic                 cStart;
  logic                 cAckn;
  logic                 cRowEnd;
  logic                 cDone;
  mbxWordPkg::wordMask  cLoad;
  int                   cRow;
  int                   startsInRow;
  int                   ackIdx;
  mbxWordPkg::wordMask  expectRq;
  mbxWordPkg::wordMask  pendModel;
  mbxWordPkg::wordIndex selModel;
  string                testName;

  initial begin
    errorCount = 0;
    checkCount = 0;
  end

  function automatic mbxWordPkg::wordIndex lowestWord(mbxWordPkg::wordMask m);
    for (int i = 0; i < mbxWordPkg::wordCount; i++) begin
      if (m[i]) begin
        return mbxWordPkg::wordIndex'(i);
      end
    end
    return '0;
  endfunction

  task automatic compareValue(string field, int expected, int actual);
    checkCount++;
    if (expected != actual) begin
      errorCount++;
      $display("** Error: %s %s expected %0h actual %0h at %0t ns",
               testName, field, expected, actual, $time);
    end
  endtask

  task automatic reportProblem(string what);
    errorCount++;
    $display("Test %s failed at %0t ns, %s", testName, $time, what);
  endtask

  ////////////////////////////////////////
  // Checks per event
  ////////////////////////////////////////

  task automatic checkStart();
    benchRow row;
    logic    write;
    row   = rows[cRow];
    write = mbxCyclePkg::isWriteKind[row.kind];
    startsInRow++;
    if (startsInRow == 1) begin
      expectRq = row.expRqIn;
      ackIdx   = 0;
      compareValue("memWrRq", int'(expectRq != '0 && write), int'(memWrRq));
      compareValue("memRdRq", int'(expectRq != '0 && !write), int'(memRdRq));
      if (expectRq != '0) begin
        compareValue("memWordAdr", int'(row.expAdrSeq[0]), int'(memWordAdr));
      end
    end
    // A start that is ignored leaves the cycle as it was
    compareValue("rqIn", int'(expectRq), int'(rqIn));
    compareValue("busy", int'(expectRq != '0), int'(busy));
  endtask

  task automatic checkAckn();
    benchRow              row;
    mbxWordPkg::wordIndex word;
    row = rows[cRow];
    if (expectRq == '0 || ackIdx >= mbxWordPkg::wordCount) begin
      reportProblem("memory acknowledged a word that was not requested");
    end else begin
      word = row.expAdrSeq[ackIdx[1:0]];
      expectRq[word] = 1'b0;
      if (mbxCyclePkg::isWriteKind[row.kind]) begin
        pendModel[word] = 1'b0;
      end
      ackIdx++;
      compareValue("rqIn", int'(expectRq), int'(rqIn));
      if (expectRq != '0) begin
        compareValue("memWordAdr", int'(row.expAdrSeq[ackIdx[1:0]]), int'(memWordAdr));
      end else begin
        checkCount++;
        if (busy || memRdRq || memWrRq) begin
          reportProblem("busy did not fall after the last acknowledge");
        end
      end
    end
  endtask

  task automatic checkRowEnd();
    benchRow row;
    row = rows[cRow];
    if (startsInRow == 0) begin
      reportProblem("no cycle start was seen");
    end
    compareValue("words served", $countones(row.expRqIn), ackIdx);
    compareValue("busy", 0, int'(busy));
    compareValue("mbReqHold", int'(row.expPending != '0), int'(mbReqHold));
    // Select holds the last word written once the buffer is empty
    if (row.expPending != '0) begin
      compareValue("mbSel", int'(lowestWord(row.expPending)), int'(mbSel));
    end else begin
      compareValue("mbSel", int'(selModel), int'(mbSel));
    end
    startsInRow = 0;
  endtask

  ////////////////////////////////////////
  // Sampling
  ////////////////////////////////////////

  // Inputs are taken at the rising edge, outputs read on the falling edge
  always @(posedge clk) begin
    cReset  <= reset;
    cStart  <= cycleStart;
    cAckn   <= memAckn;
    cLoad   <= wordLoad;
    cRowEnd <= rowEnd;
    cDone   <= runDone;
    cRow    <= rowIdx;
  end

  always @(negedge clk) begin
    if (cReset) begin
      testName = "reset";
      compareValue("busy", 0, int'(busy));
      compareValue("memRdRq", 0, int'(memRdRq));
      compareValue("memWrRq", 0, int'(memWrRq));
      compareValue("mbReqHold", 0, int'(mbReqHold));
      compareValue("rqIn", 0, int'(rqIn));
      compareValue("mbSel", 0, int'(mbSel));
      pendModel   = '0;
      selModel    = '0;
      expectRq    = '0;
      ackIdx      = 0;
      startsInRow = 0;
    end else begin
      testName  = rowName(cRow);
      // Select and hold registers lag the pending flags by one cycle
      compareValue("mbReqHold", int'(pendModel != '0), int'(mbReqHold));
      compareValue("mbSel", int'(selModel), int'(mbSel));
      pendModel = pendModel | cLoad;
      if (cStart) begin
        checkStart();
      end
      if (cAckn) begin
        checkAckn();
      end
      if (pendModel != '0) begin
        selModel = lowestWord(pendModel);
      end
      if (cRowEnd) begin
        checkRowEnd();
      end
      if (cDone) begin
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      end
    end
  end

endmodule

// File: verilog/mbxControl.sv
module mbxControl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cycleStart,
  input  mbxCyclePkg::cycleKind cycleKind,
  input  mbxWordPkg::wordIndex  wordAdr,
  input  mbxWordPkg::wordMask   cacheValid,
  input  mbxWordPkg::wordMask   wordLoad,
  input  logic                  memAckn,
  output mbxWordPkg::wordMask   rqIn,
  output logic                  memRdRq,
  output logic                  memWrRq,
  output mbxWordPkg::wordIndex  memWordAdr,
  output logic                  busy,
  output mbxWordPkg::wordIndex  mbSel,
  output logic                  mbReqHold
);

  mbxWordPkg::wordMask pendingWrites;
  mbxWordPkg::wordMask newMask;
  mbxWordPkg::wordMask acknWord;

  ////////////////////////////////////////
  // Request mask, buffer, memory cycle
  ////////////////////////////////////////

  wordRequestMask wordRequestMask_i (
    .kind          (cycleKind),
    .wordAdr       (wordAdr),
    .cacheValid    (cacheValid),
    .pendingWrites (pendingWrites),
    .newMask       (newMask)
  );

  mbBufferTracker mbBufferTracker_i (
    .clk           (clk),
    .reset         (reset),
    .wordLoad      (wordLoad),
    .acknWord      (acknWord),
    .pendingWrites (pendingWrites),
    .mbSel         (mbSel),
    .mbReqHold     (mbReqHold)
  );

  memCycleControl memCycleControl_i (
    .clk        (clk),
    .reset      (reset),
    .cycleStart (cycleStart),
    .kind       (cycleKind),
    .newMask    (newMask),
    .memAckn    (memAckn),
    .rqIn       (rqIn),
    .memRdRq    (memRdRq),
    .memWrRq    (memWrRq),
    .busy       (busy),
    .memWordAdr (memWordAdr),
    .acknWord   (acknWord)
  );

endmodule

// File: verilog/memCycleControl.sv
module memCycleControl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cycleStart,
  input  mbxCyclePkg::cycleKind kind,
  input  mbxWordPkg::wordMask   newMask,
  input  logic                  memAckn,
  output mbxWordPkg::wordMask   rqIn,
  output logic                  memRdRq,
  output logic                  memWrRq,
  output logic                  busy,
  output mbxWordPkg::wordIndex  memWordAdr,
  output mbxWordPkg::wordMask   acknWord
);

  logic                writeCycle;
  logic                accept;
  logic                wordDone;
  mbxWordPkg::wordMask servedWord;

  ////////////////////////////////////////
  // Cycle start and direction
  ////////////////////////////////////////

  assign busy = |rqIn;

  // Starts while busy or with nothing to move are dropped
  assign accept = cycleStart & ~busy & (|newMask);

  assign memWrRq = busy & writeCycle;
  assign memRdRq = busy & ~writeCycle;

  ////////////////////////////////////////
  // Word being served
  ////////////////////////////////////////

  always_comb begin
    memWordAdr = '0;
    for (int i = mbxWordPkg::wordCount - 1; i >= 0; i--) begin
      if (rqIn[i]) begin
        memWordAdr = mbxWordPkg::wordIndex'(i);
      end
    end
  end

  assign servedWord = mbxWordPkg::wordMask'(1) << memWordAdr;
  assign wordDone   = memAckn & busy;

  // Buffer only hears about acknowledges of writes
  assign acknWord = (wordDone & writeCycle) ? servedWord : '0;

  ////////////////////////////////////////
  // Request register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rqIn       <= '0;
      writeCycle <= 1'b0;
    end else if (accept) begin
      rqIn       <= newMask;
      writeCycle <= mbxCyclePkg::isWriteKind[kind];
    end else if (wordDone) begin
      // Last word cleared drops busy and the request
      rqIn <= rqIn & ~servedWord;
    end
  end

  // Memory answers only requests that are outstanding
  acknWhileIdle: assert property (
    @(posedge clk) disable iff (reset)
    memAckn |-> busy
  ) else $error("memory acknowledge with no cycle active");

endmodule

// File: verilog/mbBufferTracker.sv
module mbBufferTracker (
  input  logic                 clk,
  input  logic                 reset,
  input  mbxWordPkg::wordMask  wordLoad,
  input  mbxWordPkg::wordMask  acknWord,
  output mbxWordPkg::wordMask  pendingWrites,
  output mbxWordPkg::wordIndex mbSel,
  output logic                 mbReqHold
);

  mbxWordPkg::wordIndex lowestPending;
  logic                 anyPending;

  ////////////////////////////////////////
  // Pending write flags
  ////////////////////////////////////////

  // A load on the same edge as an acknowledge keeps the word pending
  always_ff @(posedge clk) begin
    if (reset) begin
      pendingWrites <= '0;
    end else begin
      pendingWrites <= (pendingWrites & ~acknWord) | wordLoad;
    end
  end

  ////////////////////////////////////////
  // Next buffer word to write
  ////////////////////////////////////////

  assign anyPending = |pendingWrites;

  // Lowest numbered word has priority
  always_comb begin
    lowestPending = '0;
    for (int i = mbxWordPkg::wordCount - 1; i >= 0; i--) begin
      if (pendingWrites[i]) begin
        lowestPending = mbxWordPkg::wordIndex'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mbSel     <= '0;
      mbReqHold <= 1'b0;
    end else begin
      mbReqHold <= anyPending;
      // Select holds while the buffer is empty
      if (anyPending) begin
        mbSel <= lowestPending;
      end
    end
  end

  // Memory only acknowledges writes of words that are waiting in the buffer
  ackOnlyPending: assert property (
    @(posedge clk) disable iff (reset)
    (acknWord & ~pendingWrites) == '0
  ) else $error("write acknowledge for word not pending, ackn %b pending %b",
                acknWord, pendingWrites);

endmodule

// File: verilog/wordRequestMask.sv
module wordRequestMask (
  input  mbxCyclePkg::cycleKind kind,
  input  mbxWordPkg::wordIndex  wordAdr,
  input  mbxWordPkg::wordMask   cacheValid,
  input  mbxWordPkg::wordMask   pendingWrites,
  output mbxWordPkg::wordMask   newMask
);

  mbxWordPkg::wordMask addressedWord;
  mbxWordPkg::wordMask missingWords;

  ////////////////////////////////////////
  // Per word terms
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < mbxWordPkg::wordCount; i++) begin
      // Decode of the single word address
      addressedWord[i] = (wordAdr == mbxWordPkg::wordIndex'(i));
      // Words the cache does not yet hold
      missingWords[i] = ~cacheValid[i];
    end
  end

  ////////////////////////////////////////
  // Request mask by cycle kind
  ////////////////////////////////////////

  always_comb begin
    newMask = '0;
    if (kind == mbxCyclePkg::oneWordRead) begin
      newMask = addressedWord;
    end else if (mbxCyclePkg::isFillKind[kind]) begin
      newMask = missingWords;
    end else if (mbxCyclePkg::isWriteKind[kind]) begin
      // Write out whatever sits in the buffer waiting
      newMask = pendingWrites;
    end
  end

endmodule

// File: verilog/mbxCyclePkg.sv
package mbxCyclePkg;

  ////////////////////////////////////////
  // Memory cycle kinds
  ////////////////////////////////////////

  localparam int kindCount = 8;

  typedef enum logic [2:0] {
    coreRead     = 3'd0,
    oneWordRead  = 3'd1,
    pageRefill   = 3'd2,
    writeback    = 3'd3,
    oneWordWrite = 3'd4
  } cycleKind;

  // Kinds that fetch every word the cache is missing
  localparam logic [kindCount-1:0] isFillKind =
    (kindCount'(1) << coreRead) | (kindCount'(1) << pageRefill);

  // Kinds that move words from the memory buffer out to memory
  localparam logic [kindCount-1:0] isWriteKind =
    (kindCount'(1) << writeback) | (kindCount'(1) << oneWordWrite);

endpackage

// File: verilog/mbxWordPkg.sv
package mbxWordPkg;

  ////////////////////////////////////////
  // Block and memory buffer geometry
  ////////////////////////////////////////

  // Words per block, and words held in the memory buffer
  localparam int wordCount = 4;

  localparam int wordIndexWidth = $clog2(wordCount);

  // Word address within a block
  typedef logic [wordIndexWidth-1:0] wordIndex;

  // One bit per word with bit i for word i
  typedef logic [wordCount-1:0] wordMask;

endpackage
